// ==== hw/apu_pkg.sv ====
`default_nettype none

package apu_pkg;

	typedef logic [7:0]  data_t;		// one gpr byte
	typedef logic [15:0] instr_t;		// microcode word
	typedef logic [3:0]  reg_idx_t;		// gpr number

	// instruction class, instr[15:12]
	typedef enum logic [3:0] {
		alu_imm_0 = 4'd0,
		alu_imm_1 = 4'd1,
		alu_imm_2 = 4'd2,
		alu_imm_3 = 4'd3,
		alu_imm_4 = 4'd4,
		alu_imm_5 = 4'd5,
		alu_imm_6 = 4'd6,
		alu_imm_7 = 4'd7,
		alu_reg   = 4'd8,
		jr        = 4'd10,
		out_port  = 4'd11,
		wait_pin  = 4'd12,
		misc      = 4'd15
	} op_class_e;

	typedef enum logic [2:0] {
		fn_ld, fn_and, fn_or, fn_xor, fn_add, fn_sub, fn_cmp, fn_tst
	} alu_func_e;

	// 9..14 reserved, never taken
	typedef enum logic [3:0] {
		jc_always = 4'd0,
		jc_z      = 4'd1,
		jc_c      = 4'd2,
		jc_nz     = 4'd3,
		jc_gt     = 4'd4,	// !c & !z
		jc_le     = 4'd5,	// c | z
		jc_nc     = 4'd6,
		jc_n      = 4'd7,
		jc_nn     = 4'd8,
		jc_never  = 4'd15
	} jump_cond_e;

	typedef enum logic [4:0] {
		pin_one, pin_hsync_start, pin_hblank, pin_vsync, pin_vblank, pin_line_start
	} pin_sel_e;

	typedef enum logic [3:0] {
		port_covox  = 4'd0,
		port_border = 4'd1
	} port_sel_e;

	typedef struct packed {
		logic z;
		logic c;
		logic n;
	} flags_t;

	// decoded instruction as seen by datapath
	typedef struct packed {
		op_class_e  op;
		alu_func_e  func;
		reg_idx_t   dst;
		reg_idx_t   src;
		data_t      imm;
		logic       use_imm;
		logic       write_dst;
		logic       write_flags;
		logic       out_en;
		port_sel_e  port;
	} dec_t;

	typedef struct packed {
		logic hsync_start;
		logic hblank;
		logic vsync;
		logic vblank;
		logic line_start;
	} video_pins_t;

	typedef struct packed {
		data_t  val;
		flags_t flags;
	} alu_res_t;

	localparam instr_t INSTR_STOP = 16'hFFFF;	// hold pc, raise ready
	localparam instr_t INSTR_NOP  = 16'hFFFE;	// forced while halted

endpackage

`default_nettype wire

// ==== hw/apu_code_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu_code_ram #(
	parameter int CODE_AW = 8
) (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  code_wen,
	input  wire apu_pkg::data_t  code_wdata,
	input  wire [CODE_AW:0]      code_waddr,	// byte address
	input  wire [CODE_AW-1:0]    rd_addr,
	output apu_pkg::instr_t      instr
);

	apu_pkg::instr_t mem [0:2**CODE_AW-1];	// microcode words
	apu_pkg::data_t  lo_byte;				// pending low half

	logic wr_lo;
	logic wr_hi;

	assign wr_lo = code_wen && !code_waddr[0];	// even byte, hold it
	assign wr_hi = code_wen && code_waddr[0];	// odd byte completes word

	always_ff @(posedge clk)
	begin
		if (wr_lo)
			lo_byte <= code_wdata;
		if (wr_hi)
			mem[code_waddr[CODE_AW:1]] <= {code_wdata, lo_byte};
	end

	// sync read at pc_next, word shows up next cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			instr <= '0;
		else
			instr <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== hw/apu_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu_seq #(
	parameter int CODE_AW = 8
) (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        halt,
	input  wire apu_pkg::instr_t       instr,
	input  wire apu_pkg::flags_t       flags,
	input  wire apu_pkg::video_pins_t  video,
	output logic [CODE_AW-1:0]         pc_next,
	output apu_pkg::dec_t              dec,
	output logic                       rdy
);

	apu_pkg::instr_t    ix;		// word actually executed
	apu_pkg::op_class_e op;
	logic [CODE_AW-1:0] pc;
	logic [CODE_AW-1:0] pc_inc;
	logic [CODE_AW-1:0] pc_rel;
	logic               jc_take;
	logic               pin_val;
	logic               wait_done;
	logic               is_stop;

	assign ix      = halt ? apu_pkg::INSTR_NOP : instr;	// halt override
	assign op      = apu_pkg::op_class_e'(ix[15:12]);
	assign is_stop = (ix == apu_pkg::INSTR_STOP);
	assign pc_inc  = pc + CODE_AW'(1);
	assign pc_rel  = pc + CODE_AW'($signed(ix[7:0]));	// rel8 from jr's own address

	always_comb
	begin
		case (apu_pkg::jump_cond_e'(ix[11:8]))
			apu_pkg::jc_always: jc_take = 1'b1;
			apu_pkg::jc_z:      jc_take = flags.z;
			apu_pkg::jc_c:      jc_take = flags.c;
			apu_pkg::jc_nz:     jc_take = !flags.z;
			apu_pkg::jc_gt:     jc_take = !flags.c && !flags.z;
			apu_pkg::jc_le:     jc_take = flags.c || flags.z;
			apu_pkg::jc_nc:     jc_take = !flags.c;
			apu_pkg::jc_n:      jc_take = flags.n;
			apu_pkg::jc_nn:     jc_take = !flags.n;
			default:            jc_take = 1'b0;	// reserved and never
		endcase
	end

	always_comb
	begin
		case (apu_pkg::pin_sel_e'(ix[4:0]))
			apu_pkg::pin_one:         pin_val = 1'b1;
			apu_pkg::pin_hsync_start: pin_val = video.hsync_start;
			apu_pkg::pin_hblank:      pin_val = video.hblank;
			apu_pkg::pin_vsync:       pin_val = video.vsync;
			apu_pkg::pin_vblank:      pin_val = video.vblank;
			apu_pkg::pin_line_start:  pin_val = video.line_start;
			default:                  pin_val = 1'b0;
		endcase
	end

	assign wait_done = pin_val ^ ix[11];	// bit 11 set, wait for low

	always_comb
	begin
		if (halt)
			pc_next = '0;	// restart from 0
		else
		begin
			case (op)
				apu_pkg::jr:       pc_next = jc_take ? pc_rel : pc_inc;
				apu_pkg::wait_pin: pc_next = wait_done ? pc_inc : pc;	// spin on pin
				default:           pc_next = is_stop ? pc : pc_inc;
			endcase
		end
	end

	// field split, register dst in [11:8] for all forms
	always_comb
	begin
		dec      = '0;
		dec.op   = op;
		dec.dst  = ix[11:8];
		dec.src  = ix[3:0];
		dec.imm  = ix[7:0];
		dec.port = apu_pkg::port_sel_e'(ix[3:0]);
		case (op)
			apu_pkg::alu_imm_0, apu_pkg::alu_imm_1, apu_pkg::alu_imm_2, apu_pkg::alu_imm_3,
			apu_pkg::alu_imm_4, apu_pkg::alu_imm_5, apu_pkg::alu_imm_6, apu_pkg::alu_imm_7:
			begin
				dec.func        = apu_pkg::alu_func_e'(ix[14:12]);
				dec.use_imm     = 1'b1;
				dec.write_flags = 1'b1;
			end
			apu_pkg::alu_reg:
			begin
				dec.func        = apu_pkg::alu_func_e'(ix[6:4]);
				dec.write_flags = 1'b1;
			end
			apu_pkg::out_port: dec.out_en = 1'b1;
			default: dec.out_en = 1'b0;	// jr, wait, misc, unused codes
		endcase
		// cmp and tst only touch flags
		dec.write_dst = dec.write_flags && (dec.func != apu_pkg::fn_cmp)
			&& (dec.func != apu_pkg::fn_tst);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pc  <= '0;
			rdy <= 1'b0;
		end
		else
		begin
			pc  <= pc_next;
			rdy <= is_stop;	// level, follows stop a cycle late
		end
	end

endmodule

`default_nettype wire

// ==== hw/apu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu_alu (
	input  wire apu_pkg::dec_t     dec,
	input  wire apu_pkg::data_t    dst_val,
	input  wire apu_pkg::data_t    src_val,
	input  wire apu_pkg::flags_t   flags,
	output apu_pkg::alu_res_t      res
);

	apu_pkg::data_t opnd;	// imm or src reg
	apu_pkg::data_t val;
	logic [8:0]     sum;	// bit 8 is carry out
	logic [8:0]     diff;	// bit 8 is borrow
	logic           carry;

	assign opnd = dec.use_imm ? dec.imm : src_val;
	assign sum  = {1'b0, dst_val} + {1'b0, opnd};
	assign diff = {1'b0, dst_val} - {1'b0, opnd};

	always_comb
	begin
		carry = 1'b0;	// logic ops clear c
		case (dec.func)
			apu_pkg::fn_and, apu_pkg::fn_tst: val = dst_val & opnd;
			apu_pkg::fn_or:  val = dst_val | opnd;
			apu_pkg::fn_xor: val = dst_val ^ opnd;
			apu_pkg::fn_add:
			begin
				val   = sum[7:0];
				carry = sum[8];
			end
			apu_pkg::fn_sub, apu_pkg::fn_cmp:
			begin
				val   = diff[7:0];
				carry = diff[8];	// dst < opnd unsigned
			end
			default: val = opnd;	// ld
		endcase
	end

	always_comb
	begin
		res.val = val;
		if (dec.write_flags)
		begin
			res.flags.z = (val == '0);
			res.flags.c = carry;
			res.flags.n = val[7];
		end
		else
			res.flags = flags;	// non-alu op keeps flags
	end

endmodule

`default_nettype wire

// ==== hw/apu_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu_regs (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire apu_pkg::dec_t       dec,
	input  wire apu_pkg::alu_res_t   res,
	output apu_pkg::data_t           dst_val,
	output apu_pkg::data_t           src_val,
	output apu_pkg::flags_t          flags
);

	apu_pkg::data_t gpr [0:15];	// general regs

	// async read, both operands same cycle
	assign dst_val = gpr[dec.dst];
	assign src_val = gpr[dec.src];

	always_ff @(posedge clk)
	begin
		if (dec.write_dst)
			gpr[dec.dst] <= res.val;	// visible to next instr
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			flags <= '0;
		else if (dec.write_flags)
			flags <= res.flags;
	end

endmodule

`default_nettype wire

// ==== hw/apu_out_ports.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu_out_ports (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire apu_pkg::dec_t   dec,
	input  wire apu_pkg::data_t  dst_val,
	output apu_pkg::data_t       covox,
	output logic                 covox_we,
	output logic [5:0]           border,
	output logic                 border_we
);

	logic hit_covox;
	logic hit_border;

	// unknown port numbers just drop the write
	assign hit_covox  = dec.out_en && (dec.port == apu_pkg::port_covox);
	assign hit_border = dec.out_en && (dec.port == apu_pkg::port_border);

	always_ff @(posedge clk)
	begin
		if (hit_covox)
			covox <= dst_val;
		if (hit_border)
			border <= dst_val[5:0];	// 6-bit colour
	end

	// one-cycle strobes, aligned with the data regs
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			covox_we  <= 1'b0;
			border_we <= 1'b0;
		end
		else
		begin
			covox_we  <= hit_covox;
			border_we <= hit_border;
		end
	end

endmodule

`default_nettype wire

// ==== hw/apu.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu #(
	parameter int CODE_AW = 8	// 256 code words
) (
	input  wire                        clk,
	input  wire                        rst_n,
	// host code load
	input  wire                        code_wen,
	input  wire apu_pkg::data_t        code_wdata,
	input  wire [CODE_AW:0]            code_waddr,
	// control
	input  wire                        apu_halt,
	output wire                        apu_rdy,
	// video timing
	input  wire apu_pkg::video_pins_t  video,
	// ports
	output apu_pkg::data_t             covox,
	output wire                        covox_we,
	output wire [5:0]                  border,
	output wire                        border_we
);

	wire [CODE_AW-1:0]          pc_next;
	apu_pkg::instr_t            instr;
	apu_pkg::dec_t              dec;
	apu_pkg::data_t             dst_val;
	apu_pkg::data_t             src_val;
	apu_pkg::flags_t            flags;
	apu_pkg::alu_res_t          res;

	apu_code_ram #(
		.CODE_AW    (CODE_AW)
	) u_code_ram (
		.clk        (clk),
		.rst_n      (rst_n),
		.code_wen   (code_wen),
		.code_wdata (code_wdata),
		.code_waddr (code_waddr),
		.rd_addr    (pc_next),
		.instr      (instr)
	);

	apu_seq #(
		.CODE_AW (CODE_AW)
	) u_seq (
		.clk     (clk),
		.rst_n   (rst_n),
		.halt    (apu_halt),
		.instr   (instr),
		.flags   (flags),
		.video   (video),
		.pc_next (pc_next),
		.dec     (dec),
		.rdy     (apu_rdy)
	);

	apu_alu u_alu (
		.dec     (dec),
		.dst_val (dst_val),
		.src_val (src_val),
		.flags   (flags),
		.res     (res)
	);

	apu_regs u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.dec     (dec),
		.res     (res),
		.dst_val (dst_val),
		.src_val (src_val),
		.flags   (flags)
	);

	apu_out_ports u_out_ports (
		.clk       (clk),
		.rst_n     (rst_n),
		.dec       (dec),
		.dst_val   (dst_val),
		.covox     (covox),
		.covox_we  (covox_we),
		.border    (border),
		.border_we (border_we)
	);

endmodule

`default_nettype wire

// ==== tb/apu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu_checker (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  apu_rdy,
	input  wire apu_pkg::data_t  covox,
	input  wire                  covox_we,
	input  wire [5:0]            border,
	input  wire                  border_we
);

	int             exp_port [$];	// 0 covox, 1 border
	apu_pkg::data_t exp_val [$];
	string          test_name = "";
	int             cyc = 0;		// negedges since start or restart
	int             bound = 0;
	int             not_before = -1;	// first event must come after this cycle
	int             seen = 0;
	int             errs = 0;
	bit             active = 1'b0;
	bit             quiet = 1'b0;	// ready seen, strobes now illegal
	int             pass_cnt = 0;
	int             fail_cnt = 0;

	task automatic expect_event(input int port, input apu_pkg::data_t val);
		exp_port.push_back(port);
		exp_val.push_back(val);
	endtask

	task automatic start_test(input string name, input int max_cycles, input int first_after);
		test_name  = name;
		bound      = max_cycles;
		not_before = first_after;
		seen       = 0;
		errs       = 0;
		cyc        = 0;
		quiet      = 1'b0;
		active     = 1'b1;
	endtask

	task automatic check_strobe(input string sig, input int port, input apu_pkg::data_t val);
		int             p;
		apu_pkg::data_t v;
		if (quiet || apu_rdy)	// stop already ran, no out can be in flight
		begin
			$display("test %s: %s write at %0t after ready went high", test_name, sig, $time);
			errs++;
		end
		else if (exp_port.size() == 0)
		begin
			$display("test %s: unexpected %s write of %02h at %0t", test_name, sig, val, $time);
			errs++;
		end
		else
		begin
			p = exp_port.pop_front();
			v = exp_val.pop_front();
			if (p != port)
			begin
				$display("[ERROR] %0t %s_we exp 0 got 1 (wanted the other port, value %02h)",
					$time, sig, v);
				errs++;
			end
			else if (v != val)
			begin
				$display("[ERROR] %0t %s exp %02h got %02h", $time, sig, v, val);
				errs++;
			end
			if (seen == 0 && cyc <= not_before)
			begin
				$display("test %s: first write at cycle %0d, before the pin changed at %0d",
					test_name, cyc, not_before);
				errs++;
			end
			seen++;
		end
	endtask

	// outputs are registered on posedge, so look at them half a cycle later
	always @(negedge clk)
	begin
		if (active && rst_n)
		begin
			cyc = cyc + 1;
			if (covox_we)
				check_strobe("covox", 0, covox);
			if (border_we)
				check_strobe("border", 1, {2'b00, border});
		end
	end

	task automatic wait_rdy(output bit ok);
		int n;
		n   = 0;	// own count, bound per pass
		cyc = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!apu_rdy && n < bound);
		ok = apu_rdy;
		if (!ok)
		begin
			$display("test %s: ready did not rise within %0d cycles", test_name, bound);
			errs++;
		end
		else
		begin
			quiet = 1'b1;	// stop holds, nothing else may come out
			repeat (4) @(negedge clk);
			quiet = 1'b0;
		end
	endtask

	task automatic end_test;
		if (exp_port.size() != 0)
		begin
			$display("test %s: %0d expected port writes never showed up",
				test_name, exp_port.size());
			errs++;
			exp_port.delete();
			exp_val.delete();
		end
		if (errs == 0)
		begin
			$display("test %s: ok, %0d port writes", test_name, seen);
			pass_cnt++;
		end
		else
		begin
			$display("test %s: %0d errors", test_name, errs);
			fail_cnt++;
		end
		active = 1'b0;
	endtask

	task automatic summary;
		$display("summary: %0d run, %0d ok, %0d with errors",
			pass_cnt + fail_cnt, pass_cnt, fail_cnt);
	endtask

endmodule

`default_nettype wire

// ==== tb/apu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu_tb;

	localparam int CODE_AW   = 8;
	localparam int MAX_TESTS = 16;

	logic                  clk;
	logic                  rst_n;
	logic                  code_wen;
	apu_pkg::data_t        code_wdata;
	logic [CODE_AW:0]      code_waddr;
	logic                  apu_halt;
	apu_pkg::video_pins_t  video;
	wire                   apu_rdy;
	apu_pkg::data_t        covox;
	wire                   covox_we;
	wire [5:0]             border;
	wire                   border_we;

	// per-test table read from the pattern file
	string           t_name [0:MAX_TESTS-1];
	int              t_ncode [0:MAX_TESTS-1];
	int              t_pin_mode [0:MAX_TESTS-1];	// 0 none, 1 high pulse, 2 low pulse
	int              t_pin_at [0:MAX_TESTS-1];
	int              t_restarts [0:MAX_TESTS-1];
	int              t_nev [0:MAX_TESTS-1];
	int              t_bound [0:MAX_TESTS-1];
	apu_pkg::instr_t code_q [$];	// all programs back to back
	int              ev_port_q [$];
	apu_pkg::data_t  ev_val_q [$];
	int              n_tests = 0;
	bit              load_err = 1'b0;

	apu #(
		.CODE_AW    (CODE_AW)
	) dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.code_wen   (code_wen),
		.code_wdata (code_wdata),
		.code_waddr (code_waddr),
		.apu_halt   (apu_halt),
		.apu_rdy    (apu_rdy),
		.video      (video),
		.covox      (covox),
		.covox_we   (covox_we),
		.border     (border),
		.border_we  (border_we)
	);

	apu_checker chk (
		.clk       (clk),
		.rst_n     (rst_n),
		.apu_rdy   (apu_rdy),
		.covox     (covox),
		.covox_we  (covox_we),
		.border    (border),
		.border_we (border_we)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns
	end

	task automatic read_patterns;
		int    fd;
		int    r;
		int    word;
		int    p;
		int    v;
		string tok;
		string line;
		string nm;
		fd = $fopen("tb/apu_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("could not open tb/apu_patterns.txt");
			load_err = 1'b1;
			return;
		end
		while (!$feof(fd) && n_tests < MAX_TESTS)
		begin
			r = $fscanf(fd, "%s", tok);
			if (r != 1)
				break;
			if (tok[0] == "#")
				r = $fgets(line, fd);	// comment, drop rest of line
			else if (tok == "test")
			begin
				r = $fscanf(fd, "%s %d %d %d %d %d %d", nm, t_ncode[n_tests],
					t_pin_mode[n_tests], t_pin_at[n_tests], t_restarts[n_tests],
					t_nev[n_tests], t_bound[n_tests]);
				if (r != 7)
				begin
					$display("bad test header after test %0d in pattern file", n_tests);
					load_err = 1'b1;
					break;
				end
				t_name[n_tests] = nm;
				for (int i = 0; i < t_ncode[n_tests]; i++)
				begin
					r = $fscanf(fd, "%h", word);
					code_q.push_back(apu_pkg::instr_t'(word));
				end
				for (int i = 0; i < t_nev[n_tests]; i++)
				begin
					r = $fscanf(fd, "%d %h", p, v);
					ev_port_q.push_back(p);
					ev_val_q.push_back(apu_pkg::data_t'(v));
				end
				n_tests++;
			end
		end
		$fclose(fd);
		if (n_tests == 0)
			load_err = 1'b1;
	endtask

	// host side: two byte writes per word, low byte first
	task automatic load_code(input int t, input int base);
		for (int i = 0; i < t_ncode[t]; i++)
		begin
			@(posedge clk);
			#1;
			code_wen   = 1'b1;
			code_waddr = (CODE_AW+1)'(2 * i);
			code_wdata = code_q[base + i][7:0];
			@(posedge clk);
			#1;
			code_waddr = (CODE_AW+1)'(2 * i + 1);
			code_wdata = code_q[base + i][15:8];
		end
		@(posedge clk);
		#1 code_wen = 1'b0;
	endtask

	task automatic pulse_pin(input int mode, input int at);
		repeat (at) @(posedge clk);
		#1 video.vblank = (mode == 1);
		@(posedge clk);
		#1 video.vblank = (mode == 2);	// back to idle level
	endtask

	task automatic run_test(input int t, input int base, input int ev_base);
		int pulse_at;
		bit ok;
		video        = '0;
		video.vblank = (t_pin_mode[t] == 2);	// low-wait needs pin high first
		load_code(t, base);
		for (int r = 0; r <= t_restarts[t]; r++)
		begin
			for (int e = 0; e < t_nev[t]; e++)
				chk.expect_event(ev_port_q[ev_base + e], ev_val_q[ev_base + e]);
		end
		pulse_at = t_pin_at[t] + int'($urandom % 8);
		chk.start_test(t_name[t], t_bound[t], (t_pin_mode[t] != 0) ? pulse_at + 1 : -1);
		apu_halt = 1'b0;
		fork
			if (t_pin_mode[t] != 0)
				pulse_pin(t_pin_mode[t], pulse_at);
			begin
				for (int r = 0; r <= t_restarts[t]; r++)
				begin
					chk.wait_rdy(ok);
					if (!ok)
						break;
					if (r < t_restarts[t])
					begin
						@(posedge clk);
						#1 apu_halt = 1'b1;	// restart from 0
						@(posedge clk);
						#1 apu_halt = 1'b0;
					end
				end
			end
		join
		@(posedge clk);
		#1 apu_halt = 1'b1;
		chk.end_test();
	endtask

	task automatic watchdog(input int cycles);
		repeat (cycles) @(posedge clk);
		$display("watchdog: run still going after %0d cycles, giving up", cycles);
		$display("tests failed");
		$finish;
	endtask

	initial
	begin
		int base;
		int ev_base;
		int wd_cycles;
		void'($urandom(8));	// seed 8
		rst_n      = 1'b0;
		code_wen   = 1'b0;
		code_wdata = '0;
		code_waddr = '0;
		apu_halt   = 1'b1;	// held through reset and loading
		video      = '0;
		read_patterns();
		wd_cycles = 40;	// reset plus slack
		for (int t = 0; t < n_tests; t++)
			wd_cycles += 2 * t_ncode[t] + 8 + (t_bound[t] + 10) * (t_restarts[t] + 1);
		fork
			watchdog(wd_cycles);
		join_none
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		base    = 0;
		ev_base = 0;
		if (!load_err)
		begin
			for (int t = 0; t < n_tests; t++)
			begin
				run_test(t, base, ev_base);
				base    += t_ncode[t];
				ev_base += t_nev[t];
			end
		end
		chk.summary();
		if (!load_err && chk.fail_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
hw/apu_pkg.sv
hw/apu_code_ram.sv
hw/apu_seq.sv
hw/apu_alu.sv
hw/apu_regs.sv
hw/apu_out_ports.sv
hw/apu.sv
tb/apu_checker.sv
tb/apu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the apu testbench with verilator, run it, look for the pass line in the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --top-module apu_tb -f files.f -o apu_sim \
	&& ./obj_dir/apu_sim | tee sim.log \
	&& grep -q "^all tests passed$" sim.log \
	&& echo "run.sh: simulation ok" \
	|| { echo "run.sh: simulation did not pass, see sim.log"; exit 1; }

// ==== tb/apu_patterns.txt ====
# test <name> <words> <pin 0 none 1 vblank high pulse 2 vblank low pulse> <pin cycle> <restarts> <events> <max cycles>
# then the hex code words (ffff stop), then event pairs <port 0 covox 1 border> <hex value>
# ld 3c, add 85, sub 50, and 0f, or a0, xor ff on r1, each sent to covox
test alu_imm 13 0 0 0 6 40
013c b100 4185 b100 5150 b100 110f b100 21a0 b100 31ff b100 ffff
0 3c 0 c1 0 71 0 01 0 a1 0 5e
# sub r2,r3 countdown with cmp r2,r4 and jr nz, then add and and in register form
test reg_loop 13 0 0 0 7 60
0205 0301 0400 b201 8253 8264 a3fd 0510 8543 b500 8513 b500 ffff
1 05 1 04 1 03 1 02 1 01 0 11 0 01
# r6=1 marks not taken, r7=2 taken; flags z, then c+n, then all clear
test jumps 87 0 0 0 20 130
0601 0702 0000
a003 b600 a002 b700 a103 b600 a002 b700 a203 b600 a002 b700
a303 b600 a002 b700 a403 b600 a002 b700 a503 b600 a002 b700
a603 b600 a002 b700 a703 b600 a002 b700 a803 b600 a002 b700
a903 b600 a002 b700 ae03 b600 a002 b700 af03 b600 a002 b700
0000 5001
a203 b600 a002 b700 a603 b600 a002 b700 a703 b600 a002 b700
a803 b600 a002 b700
0001
a103 b600 a002 b700 a303 b600 a002 b700 a403 b600 a002 b700
a503 b600 a002 b700
ffff
0 02 0 02 0 01 0 01 0 01 0 02 0 02 0 01 0 02 0 01 0 01 0 01
0 02 0 01 0 02 0 01 0 01 0 02 0 02 0 01
# wait for vblank high, then out 77
test wait_high 4 1 6 0 1 40
0177 c004 b100 ffff
0 77
# wait for vblank low, then out 66
test wait_low 4 2 6 0 1 40
0166 c804 b100 ffff
0 66
# stop, then one halt restart repeats border 19 and covox 9a
test stop_restart 5 0 0 1 2 30
0199 b101 4101 b100 ffff
1 19 0 9a
